//--- uop_pkg.sv
// shared opcodes, status bit positions, sizes, bus address map and micro-op word types
`default_nettype none

package uop_pkg;

	// ========================================================================
	// sizes
	// ========================================================================
	localparam int OP_W      = 6;
	localparam int NREGS     = 8;
	localparam int REG_SEL_W = 3;
	localparam int DATA_W    = 24;
	localparam int QDEPTH    = 8;
	localparam int QPTR_W    = 3;
	// the count has to reach QDEPTH itself, hence one bit more than the pointers
	localparam int QCNT_W    = 4;

	// ========================================================================
	// micro-op opcodes
	// ========================================================================
	localparam logic [OP_W-1:0] UO_LDIB = 6'd0;
	localparam logic [OP_W-1:0] UO_ADDW = 6'd1;
	localparam logic [OP_W-1:0] UO_ADDB = 6'd2;
	localparam logic [OP_W-1:0] UO_ADCB = 6'd3;
	localparam logic [OP_W-1:0] UO_SBCB = 6'd4;
	localparam logic [OP_W-1:0] UO_CMPB = 6'd5;
	localparam logic [OP_W-1:0] UO_ANDB = 6'd6;
	localparam logic [OP_W-1:0] UO_BITB = 6'd7;
	localparam logic [OP_W-1:0] UO_ORB  = 6'd8;
	localparam logic [OP_W-1:0] UO_EORB = 6'd9;
	localparam logic [OP_W-1:0] UO_MOV  = 6'd10;
	localparam logic [OP_W-1:0] UO_ASLB = 6'd11;
	localparam logic [OP_W-1:0] UO_LSRB = 6'd12;
	localparam logic [OP_W-1:0] UO_ROLB = 6'd13;
	localparam logic [OP_W-1:0] UO_RORB = 6'd14;
	// flag ops, each touches exactly one status bit
	localparam logic [OP_W-1:0] UO_CLC  = 6'd15;
	localparam logic [OP_W-1:0] UO_SEC  = 6'd16;
	localparam logic [OP_W-1:0] UO_CLV  = 6'd17;
	localparam logic [OP_W-1:0] UO_SEI  = 6'd18;
	localparam logic [OP_W-1:0] UO_CLI  = 6'd19;
	localparam logic [OP_W-1:0] UO_SED  = 6'd20;
	localparam logic [OP_W-1:0] UO_CLD  = 6'd21;
	localparam logic [OP_W-1:0] UO_SEB  = 6'd22;
	localparam logic [OP_W-1:0] UO_CLB  = 6'd23;

	// status word bit positions, bit 5 is unused and stays as loaded
	localparam int SR_C = 0;
	localparam int SR_Z = 1;
	localparam int SR_I = 2;
	localparam int SR_D = 3;
	localparam int SR_B = 4;
	localparam int SR_V = 6;
	localparam int SR_N = 7;

	// wishbone byte addresses, registers sit one 32-bit word apart from REG0
	localparam logic [7:0] WB_ADR_UOP  = 8'h00;
	localparam logic [7:0] WB_ADR_STAT = 8'h04;
	localparam logic [7:0] WB_ADR_REG0 = 8'h20;

	// register form of a micro-op, three register selects
	typedef struct packed {
		logic [OP_W-1:0]      op;
		logic [REG_SEL_W-1:0] dst;
		logic [REG_SEL_W-1:0] src1;
		logic [REG_SEL_W-1:0] src2;
		logic [8:0]           zero;
	} uop_reg_s;

	// immediate form, used by LDIB
	typedef struct packed {
		logic [OP_W-1:0]      op;
		logic [REG_SEL_W-1:0] dst;
		logic [6:0]           zero;
		logic [7:0]           imm8;
	} uop_imm_s;

	// one 24-bit word, decoded by opcode into either view
	typedef union packed {
		uop_reg_s r;
		uop_imm_s i;
	} uop_word_u;

endpackage

`default_nettype wire

//--- uop_if.sv
// register-file port interface between the execute unit and the register file
`default_nettype none

interface rf_port_if
	import uop_pkg::*;
();

	// three read selects, all resolved combinationally by the register file
	logic [REG_SEL_W-1:0] rd_dst_sel;
	logic [REG_SEL_W-1:0] rd_src1_sel;
	logic [REG_SEL_W-1:0] rd_src2_sel;
	logic [DATA_W-1:0]    rd_dst;
	logic [DATA_W-1:0]    rd_src1;
	logic [DATA_W-1:0]    rd_src2;

	// single write port, lands on the rising edge
	logic                 we;
	logic [REG_SEL_W-1:0] wr_sel;
	logic [DATA_W-1:0]    wr_data;

	// execute side drives the selects and the write
	modport exec (
		output rd_dst_sel, rd_src1_sel, rd_src2_sel, we, wr_sel, wr_data,
		input  rd_dst, rd_src1, rd_src2
	);

	// register file side returns the read data
	modport rf (
		input  rd_dst_sel, rd_src1_sel, rd_src2_sel, we, wr_sel, wr_data,
		output rd_dst, rd_src1, rd_src2
	);

endinterface

`default_nettype wire

//--- uop_alu.sv
// combinational micro-op ALU with result, status and register write enable
`default_nettype none

module uop_alu
	import uop_pkg::*;
(
	input  logic [OP_W-1:0]   op_i,
	input  logic [DATA_W-1:0] dst_i,
	input  logic [DATA_W-1:0] src1_i,
	input  logic [DATA_W-1:0] src2_i,
	input  logic [7:0]        s_i,
	output logic [DATA_W-1:0] o_o,
	output logic [7:0]        s_o,
	output logic              wr_en_o
);

	// low bytes widened to the full word, so carry and borrow fall into bit 8
	logic [DATA_W-1:0] d8;
	logic [DATA_W-1:0] a8;
	logic [DATA_W-1:0] b8;
	// carry in and borrow in as full-width single-bit values
	logic [DATA_W-1:0] cin;
	logic [DATA_W-1:0] bin;

	assign d8  = {{(DATA_W-8){1'b0}}, dst_i[7:0]};
	assign a8  = {{(DATA_W-8){1'b0}}, src1_i[7:0]};
	assign b8  = {{(DATA_W-8){1'b0}}, src2_i[7:0]};
	assign cin = {{(DATA_W-1){1'b0}}, s_i[SR_C]};
	// the borrow is the inverted carry, as on the 6502
	assign bin = {{(DATA_W-1){1'b0}}, ~s_i[SR_C]};

	// ========================================================================
	// result
	// ========================================================================
	always_comb
	begin
		case (op_i)
		UO_LDIB: o_o = {{(DATA_W-8){src1_i[7]}}, src1_i[7:0]};
		UO_ADDW: o_o = dst_i + src1_i + src2_i;
		UO_ADDB: o_o = d8 + a8 + b8;
		UO_ADCB: o_o = d8 + a8 + b8 + cin;
		UO_SBCB: o_o = d8 - a8 - b8 - bin;
		// compare runs the subtract but the result is only used for flags
		UO_CMPB: o_o = d8 - a8 - b8 - bin;
		UO_ANDB: o_o = d8 & a8 & b8;
		UO_BITB: o_o = d8 & a8 & b8;
		UO_ORB:  o_o = d8 | a8 | b8;
		UO_EORB: o_o = d8 ^ a8 ^ b8;
		UO_MOV:  o_o = b8;
		// shifts and rotates park the outgoing bit in bit 8
		UO_ASLB: o_o = {{(DATA_W-9){1'b0}}, dst_i[7:0], 1'b0};
		UO_LSRB: o_o = {{(DATA_W-9){1'b0}}, dst_i[0], 1'b0, dst_i[7:1]};
		UO_ROLB: o_o = {{(DATA_W-9){1'b0}}, dst_i[7:0], s_i[SR_C]};
		UO_RORB: o_o = {{(DATA_W-9){1'b0}}, dst_i[0], s_i[SR_C], dst_i[7:1]};
		default: o_o = 24'h00DEAE;
		endcase
	end

	// ========================================================================
	// status
	// ========================================================================
	always_comb
	begin
		s_o = s_i;
		case (op_i)
		UO_LDIB, UO_ADDB, UO_ANDB, UO_BITB, UO_ORB, UO_EORB, UO_MOV:
		begin
			s_o[SR_Z] = o_o[7:0] == 8'h00;
			s_o[SR_N] = o_o[7];
		end
		// the word add flags the whole register
		UO_ADDW:
		begin
			s_o[SR_Z] = o_o == '0;
			s_o[SR_N] = o_o[DATA_W-1];
		end
		UO_ADCB:
		begin
			s_o[SR_C] = o_o[8];
			s_o[SR_Z] = o_o[7:0] == 8'h00;
			s_o[SR_V] = (o_o[7] ^ src1_i[7] ^ src2_i[7]) &
				(1'b1 ^ dst_i[7] ^ src1_i[7] ^ src2_i[7]);
			s_o[SR_N] = o_o[7];
		end
		UO_SBCB:
		begin
			// a set bit 8 is a borrow, so C is stored inverted
			s_o[SR_C] = ~o_o[8];
			s_o[SR_Z] = o_o[7:0] == 8'h00;
			s_o[SR_V] = (1'b1 ^ o_o[7] ^ src1_i[7] ^ src2_i[7]) &
				(dst_i[7] ^ src1_i[7] ^ src2_i[7]);
			s_o[SR_N] = o_o[7];
		end
		UO_CMPB, UO_ASLB, UO_LSRB, UO_ROLB, UO_RORB:
		begin
			s_o[SR_C] = o_o[8];
			s_o[SR_Z] = o_o[7:0] == 8'h00;
			s_o[SR_N] = o_o[7];
		end
		UO_CLC:  s_o[SR_C] = 1'b0;
		UO_SEC:  s_o[SR_C] = 1'b1;
		UO_CLV:  s_o[SR_V] = 1'b0;
		UO_SEI:  s_o[SR_I] = 1'b1;
		UO_CLI:  s_o[SR_I] = 1'b0;
		UO_SED:  s_o[SR_D] = 1'b1;
		UO_CLD:  s_o[SR_D] = 1'b0;
		UO_SEB:  s_o[SR_B] = 1'b1;
		UO_CLB:  s_o[SR_B] = 1'b0;
		default: s_o = 8'h00;
		endcase
	end

	// only ops that produce a register result write back
	always_comb
	begin
		case (op_i)
		UO_LDIB, UO_ADDW, UO_ADDB, UO_ADCB, UO_SBCB, UO_ANDB, UO_ORB, UO_EORB,
		UO_MOV, UO_ASLB, UO_LSRB, UO_ROLB, UO_RORB:
			wr_en_o = 1'b1;
		default:
			wr_en_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- uop_regfile.sv
// eight-entry register file with three execute read ports, a host read port and one write port
`default_nettype none

module uop_regfile
	import uop_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	rf_port_if.rf                rf,
	input  logic [REG_SEL_W-1:0] host_sel_i,
	output logic [DATA_W-1:0]    host_data_o
);

	logic [DATA_W-1:0] regs [NREGS];

	// the architectural registers start at zero after reset
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (rf.we)
			regs[rf.wr_sel] <= rf.wr_data;
	end

	// reads are asynchronous and see the old value during a write cycle
	assign rf.rd_dst  = regs[rf.rd_dst_sel];
	assign rf.rd_src1 = regs[rf.rd_src1_sel];
	assign rf.rd_src2 = regs[rf.rd_src2_sel];

	// the bus slave registers this on its ack
	assign host_data_o = regs[host_sel_i];

endmodule

`default_nettype wire

//--- uop_queue.sv
// eight-entry circular FIFO of micro-op words with count, full and empty
`default_nettype none

module uop_queue
	import uop_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              push_i,
	input  uop_word_u         push_word_i,
	input  logic              pop_i,
	output logic              valid_o,
	output uop_word_u         word_o,
	output logic              full_o,
	output logic [QCNT_W-1:0] count_o
);

	uop_word_u         mem [QDEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] count;

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			case ({push_i, pop_i})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// storage only, the pointers decide what is live
	always_ff @(posedge clk_i)
	begin
		if (push_i)
			mem[wr_ptr] <= push_word_i;
	end

	// head entry is presented without a read latency
	assign word_o  = mem[rd_ptr];
	assign valid_o = count != '0;
	assign full_o  = count == QCNT_W'(QDEPTH);
	assign count_o = count;

endmodule

`default_nettype wire

//--- uop_exec.sv
// two-stage issue and execute pipeline with status register and register write-back
`default_nettype none

module uop_exec
	import uop_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      q_valid_i,
	input  uop_word_u q_word_i,
	output logic      q_pop_o,
	rf_port_if.exec   rf,
	output logic [7:0] sr_o,
	output logic      busy_o
);

	// stage 1 is the issue register, stage 2 the execute register
	logic      s1_valid;
	logic      s2_valid;
	uop_word_u s1_word;
	uop_word_u s2_word;
	logic [7:0] sr_q;

	logic [DATA_W-1:0] alu_src1;
	logic [DATA_W-1:0] alu_o;
	logic [7:0]        alu_s;
	logic              alu_wr_en;

	// nothing downstream can stall, so the head is taken whenever it exists
	assign q_pop_o = q_valid_i;

	// ========================================================================
	// pipeline control and status register
	// ========================================================================
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			sr_q     <= 8'h00;
		end
		else
		begin
			s1_valid <= q_pop_o;
			s2_valid <= s1_valid;
			// status updates together with the register write at the end of stage 2
			if (s2_valid)
				sr_q <= alu_s;
		end
	end

	// payload moves along with the valid bits
	always_ff @(posedge clk_i)
	begin
		if (q_pop_o)
			s1_word <= q_word_i;
		s2_word <= s1_word;
	end

	// ========================================================================
	// stage 2 register read and ALU
	// ========================================================================
	// registers are read in stage 2, so a back-to-back dependent op sees the write
	assign rf.rd_dst_sel  = s2_word.r.dst;
	assign rf.rd_src1_sel = s2_word.r.src1;
	assign rf.rd_src2_sel = s2_word.r.src2;

	// LDIB uses the immediate view, every other op the register view
	assign alu_src1 = (s2_word.i.op == UO_LDIB) ?
		{{(DATA_W-8){1'b0}}, s2_word.i.imm8} : rf.rd_src1;

	uop_alu u_alu (
		.op_i    (s2_word.r.op),
		.dst_i   (rf.rd_dst),
		.src1_i  (alu_src1),
		.src2_i  (rf.rd_src2),
		.s_i     (sr_q),
		.o_o     (alu_o),
		.s_o     (alu_s),
		.wr_en_o (alu_wr_en)
	);

	// write-back only for ops the ALU marks as writing
	assign rf.we      = s2_valid & alu_wr_en;
	assign rf.wr_sel  = s2_word.r.dst;
	assign rf.wr_data = alu_o;

	assign sr_o   = sr_q;
	assign busy_o = q_valid_i | s1_valid | s2_valid;

endmodule

`default_nettype wire

//--- uop_wb_slave.sv
// Wishbone classic slave with address decode, push stall on a full queue and read-back mux
`default_nettype none

module uop_wb_slave
	import uop_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  logic [7:0]           adr_i,
	input  logic [31:0]          dat_i,
	input  logic [3:0]           sel_i,
	output logic [31:0]          dat_o,
	output logic                 ack_o,
	output logic                 q_push_o,
	output uop_word_u            q_push_word_o,
	input  logic                 q_full_i,
	input  logic [QCNT_W-1:0]    q_count_i,
	input  logic [7:0]           sr_i,
	input  logic                 busy_i,
	output logic [REG_SEL_W-1:0] host_sel_o,
	input  logic [DATA_W-1:0]    host_data_i
);

	logic        ack_q;
	logic [31:0] dat_q;
	logic [31:0] rd_word;
	logic        cyc_act;
	logic        adr_uop;
	logic        adr_stat;
	logic        adr_reg;
	logic        uop_wr;

	// a strobe already acked is not served again while the master drops it
	assign cyc_act = cyc_i & stb_i & ~ack_q;

	// ========================================================================
	// address decode
	// ========================================================================
	assign adr_uop  = adr_i == WB_ADR_UOP;
	assign adr_stat = adr_i == WB_ADR_STAT;
	assign adr_reg  = (adr_i >= WB_ADR_REG0) &&
		(adr_i < WB_ADR_REG0 + 8'(4 * NREGS)) && (adr_i[1:0] == 2'b00);

	// REG0 is 32-byte aligned, so the word index is the register number
	assign host_sel_o = adr_i[2 +: REG_SEL_W];

	// push waits while the queue is full, the ack is held with it
	assign uop_wr   = cyc_act & we_i & adr_uop;
	assign q_push_o = uop_wr & ~q_full_i;

	// micro-op occupies the low three byte lanes, unselected lanes read as zero
	assign q_push_word_o = {
		sel_i[2] ? dat_i[23:16] : 8'h00,
		sel_i[1] ? dat_i[15:8]  : 8'h00,
		sel_i[0] ? dat_i[7:0]   : 8'h00
	};

	// status word is SR in 7:0, busy in 8 and the queue count in 19:16
	always_comb
	begin
		if (adr_stat)
			rd_word = {12'h000, q_count_i, 7'h00, busy_i, sr_i};
		else if (adr_reg)
			rd_word = {{(32-DATA_W){1'b0}}, host_data_i};
		else
			rd_word = 32'h0000_0000;
	end

	// ========================================================================
	// registered ack and read data
	// ========================================================================
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= cyc_act & ~(uop_wr & q_full_i);
	end

	// read data is captured on the same edge that raises ack
	always_ff @(posedge clk_i)
	begin
		if (cyc_act & ~we_i)
			dat_q <= rd_word;
	end

	assign ack_o = ack_q;
	assign dat_o = dat_q;

endmodule

`default_nettype wire

//--- uop_cluster_top.sv
// top level of the micro-op execute cluster, Wishbone slave ports outside
`default_nettype none

module uop_cluster_top
	import uop_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [7:0]  adr_i,
	input  logic [31:0] dat_i,
	input  logic [3:0]  sel_i,
	output logic [31:0] dat_o,
	output logic        ack_o
);

	// slave to queue
	logic              q_push;
	uop_word_u         q_push_word;
	logic              q_full;
	logic [QCNT_W-1:0] q_count;

	// queue to execute unit
	logic              q_valid;
	uop_word_u         q_word;
	logic              q_pop;

	// execute unit and register file back to the slave
	logic [7:0]           sr;
	logic                 busy;
	logic [REG_SEL_W-1:0] host_sel;
	logic [DATA_W-1:0]    host_data;

	rf_port_if rf_bus ();

	uop_wb_slave u_wb (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.cyc_i         (cyc_i),
		.stb_i         (stb_i),
		.we_i          (we_i),
		.adr_i         (adr_i),
		.dat_i         (dat_i),
		.sel_i         (sel_i),
		.dat_o         (dat_o),
		.ack_o         (ack_o),
		.q_push_o      (q_push),
		.q_push_word_o (q_push_word),
		.q_full_i      (q_full),
		.q_count_i     (q_count),
		.sr_i          (sr),
		.busy_i        (busy),
		.host_sel_o    (host_sel),
		.host_data_i   (host_data)
	);

	uop_queue u_queue (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (q_push),
		.push_word_i (q_push_word),
		.pop_i       (q_pop),
		.valid_o     (q_valid),
		.word_o      (q_word),
		.full_o      (q_full),
		.count_o     (q_count)
	);

	uop_exec u_exec (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.q_valid_i (q_valid),
		.q_word_i  (q_word),
		.q_pop_o   (q_pop),
		.rf        (rf_bus.exec),
		.sr_o      (sr),
		.busy_o    (busy)
	);

	uop_regfile u_rf (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.rf          (rf_bus.rf),
		.host_sel_i  (host_sel),
		.host_data_o (host_data)
	);

endmodule

`default_nettype wire

//--- uop_checker.sv
// concurrent assertions on the Wishbone ack handshake, queue pops and register write-back
`default_nettype none

module uop_checker
	import uop_pkg::*;
(
	input logic                    clk_i,
	input logic                    rst_i,
	input logic                    cyc_i,
	input logic                    stb_i,
	input logic                    ack_i,
	input logic                    q_push_i,
	input logic                    q_pop_i,
	input logic                    alu_wr_en_i,
	input logic [NREGS*DATA_W-1:0] regs_i
);

	// number of failed assertions so far, polled by the testbench
	int fail_count = 0;

	// entries held by the queue, rebuilt from the push and pop strobes
	int occupancy;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			occupancy <= 0;
		else
			occupancy <= occupancy + int'(q_push_i) - int'(q_pop_i);
	end

	// a classic slave acks each strobe for exactly one clock
	ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_i |=> !ack_i)
	else
	begin
		$error("ack stayed high for two cycles in a row");
		fail_count++;
	end

	// the ack rising on this edge was decided by the strobe one edge earlier
	ack_needs_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(ack_i) |-> $past(cyc_i && stb_i))
	else
	begin
		$error("ack rose without an active bus cycle");
		fail_count++;
	end

	// the execute unit may only take the head when there is one
	pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
		q_pop_i |-> occupancy != 0)
	else
	begin
		$error("queue popped while empty");
		fail_count++;
	end

	// flag ops, compares and unknown opcodes never write a register
	write_needs_enable: assert property (@(posedge clk_i) disable iff (rst_i)
		!alu_wr_en_i |=> $stable(regs_i))
	else
	begin
		$error("a register changed while the ALU write enable was low");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- uop_tb.sv
// directed testbench for the micro-op cluster with bus tasks, a reference model and compare tasks
`default_nettype none

module uop_tb;
	import uop_pkg::*;

	// cycle limits for every wait loop
	localparam int ACK_LIMIT  = 64;
	localparam int IDLE_LIMIT = 32;

	logic        clk;
	logic        rst;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [7:0]  adr;
	logic [31:0] dat_w;
	logic [3:0]  sel;
	logic [31:0] dat_r;
	logic        ack;

	// software copy of the architectural state
	logic [DATA_W-1:0] mregs [NREGS];
	logic [7:0]        msr;

	uop_cluster_top uut (
		.clk_i (clk),
		.rst_i (rst),
		.cyc_i (cyc),
		.stb_i (stb),
		.we_i  (we),
		.adr_i (adr),
		.dat_i (dat_w),
		.sel_i (sel),
		.dat_o (dat_r),
		.ack_o (ack)
	);

	bind uop_cluster_top uop_checker u_checker (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.ack_i       (ack_o),
		.q_push_i    (q_push),
		.q_pop_i     (q_pop),
		.alu_wr_en_i (u_exec.alu_wr_en),
		.regs_i      ({u_rf.regs[7], u_rf.regs[6], u_rf.regs[5], u_rf.regs[4],
			u_rf.regs[3], u_rf.regs[2], u_rf.regs[1], u_rf.regs[0]})
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================================================
	// failure reporting and compare tasks
	// ========================================================================
	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	// a failed bound assertion ends the run on the following rising edge
	always @(posedge clk)
	begin
		if (uut.u_checker.fail_count != 0)
		begin
			$display("a bound assertion failed, see the error above");
			stop_with_failure();
		end
	end

	task automatic check_reg(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_sr(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input logic [QCNT_W-1:0] got,
		input logic [QCNT_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// ========================================================================
	// bus tasks, called on a falling edge and returning on one
	// ========================================================================
	task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
		int n;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = addr;
		dat_w = data;
		sel   = 4'hf;
		n     = 0;
		// the previous ack may still be high here, so always wait one edge first
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!ack && n < ACK_LIMIT);
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		if (!ack)
		begin
			$display("no ack for a write to address 0x%h within %0d cycles", addr, ACK_LIMIT);
			stop_with_failure();
		end
	endtask

	task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
		int n;
		cyc = 1'b1;
		stb = 1'b1;
		we  = 1'b0;
		adr = addr;
		sel = 4'hf;
		n   = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!ack && n < ACK_LIMIT);
		data = dat_r;
		cyc  = 1'b0;
		stb  = 1'b0;
		if (!ack)
		begin
			$display("no ack for a read of address 0x%h within %0d cycles", addr, ACK_LIMIT);
			stop_with_failure();
		end
	endtask

	// polls the busy bit of the status word until the cluster drains
	task automatic wait_idle();
		logic [31:0] st;
		int          n;
		n = 0;
		do
		begin
			wb_read(WB_ADR_STAT, st);
			n++;
		end
		while (st[8] && n < IDLE_LIMIT);
		if (st[8])
		begin
			$display("cluster still busy after %0d status polls", IDLE_LIMIT);
			stop_with_failure();
		end
	endtask

	// ========================================================================
	// micro-op encoding and reference model
	// ========================================================================
	function automatic uop_word_u encode_reg(input logic [OP_W-1:0] op,
		input logic [REG_SEL_W-1:0] dst, input logic [REG_SEL_W-1:0] src1,
		input logic [REG_SEL_W-1:0] src2);
		uop_word_u w;
		w        = '0;
		w.r.op   = op;
		w.r.dst  = dst;
		w.r.src1 = src1;
		w.r.src2 = src2;
		return w;
	endfunction

	function automatic uop_word_u encode_imm(input logic [OP_W-1:0] op,
		input logic [REG_SEL_W-1:0] dst, input logic [7:0] imm);
		uop_word_u w;
		w        = '0;
		w.i.op   = op;
		w.i.dst  = dst;
		w.i.imm8 = imm;
		return w;
	endfunction

	function automatic logic [DATA_W-1:0] low_byte(input logic [DATA_W-1:0] x);
		return DATA_W'(x[7:0]);
	endfunction

	// byte ops keep carry or borrow in bit 8 and write the whole word back
	task automatic model_apply(input uop_word_u w);
		logic [OP_W-1:0]   op;
		logic [DATA_W-1:0] d;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] res;
		logic [7:0]        s;
		logic              c;
		logic              sgn;
		logic              writes;
		logic              nz_byte;
		op      = w.r.op;
		d       = mregs[w.r.dst];
		a       = mregs[w.r.src1];
		b       = mregs[w.r.src2];
		s       = msr;
		c       = msr[SR_C];
		// combined sign of the two source operands, used for overflow
		sgn     = a[7] ^ b[7];
		res     = '0;
		writes  = 1'b1;
		nz_byte = 1'b1;
		case (op)
		UO_LDIB: res = {{(DATA_W-8){w.i.imm8[7]}}, w.i.imm8};
		UO_ADDW:
		begin
			res     = d + a + b;
			nz_byte = 1'b0;
			s[SR_Z] = res == '0;
			s[SR_N] = res[DATA_W-1];
		end
		UO_ADDB: res = low_byte(d) + low_byte(a) + low_byte(b);
		UO_ADCB:
		begin
			res     = low_byte(d) + low_byte(a) + low_byte(b) + DATA_W'(c);
			s[SR_C] = res[8];
			s[SR_V] = (d[7] == sgn) && (res[7] != d[7]);
		end
		UO_SBCB:
		begin
			res     = low_byte(d) - low_byte(a) - low_byte(b) - DATA_W'(!c);
			s[SR_C] = !res[8];
			s[SR_V] = (d[7] != sgn) && (res[7] != d[7]);
		end
		UO_CMPB:
		begin
			res     = low_byte(d) - low_byte(a) - low_byte(b) - DATA_W'(!c);
			s[SR_C] = res[8];
			writes  = 1'b0;
		end
		UO_ANDB: res = low_byte(d) & low_byte(a) & low_byte(b);
		UO_BITB:
		begin
			res    = low_byte(d) & low_byte(a) & low_byte(b);
			writes = 1'b0;
		end
		UO_ORB:  res = low_byte(d) | low_byte(a) | low_byte(b);
		UO_EORB: res = low_byte(d) ^ low_byte(a) ^ low_byte(b);
		UO_MOV:  res = low_byte(b);
		UO_ASLB:
		begin
			res     = low_byte(d) << 1;
			s[SR_C] = d[7];
		end
		UO_LSRB:
		begin
			res     = (low_byte(d) >> 1) | (DATA_W'(d[0]) << 8);
			s[SR_C] = d[0];
		end
		UO_ROLB:
		begin
			res     = (low_byte(d) << 1) | DATA_W'(c);
			s[SR_C] = d[7];
		end
		UO_RORB:
		begin
			res     = (low_byte(d) >> 1) | (DATA_W'(c) << 7) | (DATA_W'(d[0]) << 8);
			s[SR_C] = d[0];
		end
		UO_CLC, UO_SEC, UO_CLV, UO_SEI, UO_CLI, UO_SED, UO_CLD, UO_SEB, UO_CLB:
		begin
			writes  = 1'b0;
			nz_byte = 1'b0;
			case (op)
			UO_CLC:  s[SR_C] = 1'b0;
			UO_SEC:  s[SR_C] = 1'b1;
			UO_CLV:  s[SR_V] = 1'b0;
			UO_SEI:  s[SR_I] = 1'b1;
			UO_CLI:  s[SR_I] = 1'b0;
			UO_SED:  s[SR_D] = 1'b1;
			UO_CLD:  s[SR_D] = 1'b0;
			UO_SEB:  s[SR_B] = 1'b1;
			default: s[SR_B] = 1'b0;
			endcase
		end
		// an unknown opcode writes nothing and wipes the status
		default:
		begin
			s       = 8'h00;
			writes  = 1'b0;
			nz_byte = 1'b0;
		end
		endcase
		if (nz_byte)
		begin
			s[SR_Z] = res[7:0] == 8'h00;
			s[SR_N] = res[7];
		end
		msr = s;
		if (writes)
			mregs[w.r.dst] = res;
	endtask

	// pushes one micro-op through the bus and applies it to the model
	task automatic push_uop(input uop_word_u w);
		wb_write(WB_ADR_UOP, {8'h00, w});
		model_apply(w);
	endtask

	task automatic compare_regs();
		logic [31:0] rd;
		for (int i = 0; i < NREGS; i++)
		begin
			wb_read(WB_ADR_REG0 + 8'(4 * i), rd);
			check_reg($sformatf("r%0d", i), rd[DATA_W-1:0], mregs[i]);
		end
	endtask

	// waits for the cluster to drain, then compares status and all registers
	task automatic compare_state();
		logic [31:0] st;
		wait_idle();
		wb_read(WB_ADR_STAT, st);
		check_sr("status", st[7:0], msr);
		check_bit("busy", st[8], 1'b0);
		check_count("queue count", st[19:16], '0);
		compare_regs();
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================
	task automatic test_reset_state();
		logic [31:0] st;
		wb_read(WB_ADR_STAT, st);
		check_sr("status after reset", st[7:0], 8'h00);
		check_bit("busy after reset", st[8], 1'b0);
		check_count("queue count after reset", st[19:16], '0);
		compare_regs();
	endtask

	task automatic test_load_and_add();
		logic [31:0] rd;
		push_uop(encode_imm(UO_LDIB, 3'd1, 8'h80));
		push_uop(encode_imm(UO_LDIB, 3'd2, 8'h00));
		push_uop(encode_imm(UO_LDIB, 3'd3, 8'h7f));
		compare_state();
		// a negative immediate fills the upper two bytes with ones
		wb_read(WB_ADR_REG0 + 8'd4, rd);
		check_reg("r1 sign-extended", rd[DATA_W-1:0], 24'hffff80);
		push_uop(encode_reg(UO_ADDW, 3'd4, 3'd1, 3'd3));
		push_uop(encode_reg(UO_ADDW, 3'd5, 3'd1, 3'd1));
		push_uop(encode_reg(UO_MOV, 3'd6, 3'd0, 3'd3));
		compare_state();
		push_uop(encode_reg(UO_ADDW, 3'd2, 3'd2, 3'd2));
		compare_state();
	endtask

	task automatic test_carry_edges();
		logic [31:0] rd;
		push_uop(encode_imm(UO_LDIB, 3'd0, 8'h00));
		push_uop(encode_imm(UO_LDIB, 3'd1, 8'h7f));
		push_uop(encode_imm(UO_LDIB, 3'd2, 8'h01));
		push_uop(encode_reg(UO_CLC, 3'd0, 3'd0, 3'd0));
		push_uop(encode_reg(UO_ADCB, 3'd1, 3'd2, 3'd0));
		compare_state();
		push_uop(encode_imm(UO_LDIB, 3'd1, 8'h7f));
		push_uop(encode_reg(UO_SEC, 3'd0, 3'd0, 3'd0));
		push_uop(encode_reg(UO_ADCB, 3'd1, 3'd2, 3'd0));
		compare_state();
		push_uop(encode_imm(UO_LDIB, 3'd3, 8'h80));
		push_uop(encode_reg(UO_SEC, 3'd0, 3'd0, 3'd0));
		push_uop(encode_reg(UO_SBCB, 3'd3, 3'd2, 3'd0));
		compare_state();
		push_uop(encode_imm(UO_LDIB, 3'd3, 8'h80));
		push_uop(encode_reg(UO_CLC, 3'd0, 3'd0, 3'd0));
		push_uop(encode_reg(UO_SBCB, 3'd3, 3'd2, 3'd0));
		compare_state();
		// compare and bit test only touch the flags
		push_uop(encode_imm(UO_LDIB, 3'd4, 8'h80));
		push_uop(encode_reg(UO_CMPB, 3'd4, 3'd2, 3'd0));
		push_uop(encode_reg(UO_BITB, 3'd4, 3'd2, 3'd2));
		compare_state();
		wb_read(WB_ADR_REG0 + 8'd16, rd);
		check_reg("r4 after compare", rd[DATA_W-1:0], 24'hffff80);
	endtask

	task automatic test_shifts_and_flags();
		logic [OP_W-1:0] shift_ops [4] = '{UO_ASLB, UO_LSRB, UO_ROLB, UO_RORB};
		logic [OP_W-1:0] flag_ops [9] = '{UO_CLC, UO_SEC, UO_CLV, UO_SEI, UO_CLI,
			UO_SED, UO_CLD, UO_SEB, UO_CLB};
		for (int i = 0; i < 4; i++)
		begin
			// 0xc3 has both end bits set, so the carry path is exercised both ways
			push_uop(encode_imm(UO_LDIB, 3'd5, 8'hc3));
			push_uop(encode_reg(shift_ops[i], 3'd5, 3'd0, 3'd0));
			push_uop(encode_reg(shift_ops[i], 3'd5, 3'd0, 3'd0));
			compare_state();
		end
		for (int i = 0; i < 9; i++)
		begin
			push_uop(encode_reg(flag_ops[i], 3'd0, 3'd0, 3'd0));
			compare_state();
		end
	endtask

	task automatic test_dependent_chain();
		logic [31:0] rd;
		// each add triples r7, and every one depends on the one before
		push_uop(encode_imm(UO_LDIB, 3'd7, 8'h01));
		repeat (9)
			push_uop(encode_reg(UO_ADDW, 3'd7, 3'd7, 3'd7));
		compare_state();
		wb_read(WB_ADR_REG0 + 8'd28, rd);
		check_reg("r7 after chain", rd[DATA_W-1:0], 24'h004ce3);
	endtask

	task automatic test_random();
		logic [OP_W-1:0] op;
		uop_word_u       w;
		logic [31:0]     st;
		for (int i = 0; i < 50; i++)
		begin
			// a few codes past UO_CLB land in the unknown range
			op = OP_W'($urandom_range(27, 0));
			if (op == UO_LDIB)
				w = encode_imm(op, 3'($urandom_range(7, 0)), 8'($urandom));
			else
				w = encode_reg(op, 3'($urandom_range(7, 0)), 3'($urandom_range(7, 0)),
					3'($urandom_range(7, 0)));
			push_uop(w);
			compare_state();
		end
		push_uop(encode_reg(UO_SEC, 3'd0, 3'd0, 3'd0));
		push_uop(encode_reg(UO_SEI, 3'd0, 3'd0, 3'd0));
		push_uop(encode_reg(6'd63, 3'd2, 3'd3, 3'd4));
		compare_state();
		wb_read(WB_ADR_STAT, st);
		check_sr("status after unknown opcode", st[7:0], 8'h00);
	endtask

	initial
	begin
		void'($urandom(32'h624ba064));
		rst   = 1'b1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = 8'h00;
		dat_w = 32'h0000_0000;
		sel   = 4'h0;
		msr   = 8'h00;
		for (int i = 0; i < NREGS; i++)
			mregs[i] = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		test_reset_state();
		test_load_and_add();
		test_carry_edges();
		test_shifts_and_flags();
		test_dependent_chain();
		test_random();
		if (uut.u_checker.fail_count == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			$display("a bound assertion failed during the last bus cycle");
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

//--- flist.f
uop_pkg.sv
uop_if.sv
uop_alu.sv
uop_regfile.sv
uop_queue.sv
uop_exec.sv
uop_wb_slave.sv
uop_cluster_top.sv
uop_checker.sv
uop_tb.sv
